// File: design/brisc_mem_pkg.sv
`default_nettype none

package brisc_mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned ADDRESS_WIDTH = 16;  // byte address.
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned BYTE_WIDTH = 8;
  localparam int unsigned CACHE_LINE_WIDTH = 128;
  localparam int unsigned WORDS_IN_LINE = CACHE_LINE_WIDTH / WORD_WIDTH;

  localparam int unsigned BYTE_OFFSET_WIDTH = $clog2(WORD_WIDTH / BYTE_WIDTH);
  localparam int unsigned LINE_OFFSET_WIDTH = BYTE_OFFSET_WIDTH + $clog2(WORDS_IN_LINE);

  localparam int unsigned MEM_DEPTH = 256;  // in words.
  localparam int unsigned LINE_INDEX_WIDTH = $clog2(MEM_DEPTH / WORDS_IN_LINE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access time
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned MEM_REQ_DELAY = 3;
  localparam int unsigned MEM_RESP_DELAY = 4;

  // request payload, valid travels beside it.
  typedef struct packed {
    logic store;
    logic [ADDRESS_WIDTH-1:0] addr;
    logic [CACHE_LINE_WIDTH-1:0] data;
  } mem_req_t;

  // line returned to the cache.
  typedef struct packed {
    logic [ADDRESS_WIDTH-1:0] addr;
    logic [CACHE_LINE_WIDTH-1:0] data;
  } mem_fill_t;

endpackage

`default_nettype wire

// File: design/mem_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// delayed request as it leaves the request pipeline.
interface mem_req_if
  import brisc_mem_pkg::*;
();

  logic valid;  // one-cycle transfer.
  logic store;  // 1 = evict, 0 = fill read.
  logic [ADDRESS_WIDTH-1:0] addr;
  logic [CACHE_LINE_WIDTH-1:0] data;

  modport source (
    output valid,
    output store,
    output addr,
    output data
  );

  modport sink (
    input valid,
    input store,
    input addr,
    input data
  );

endinterface

`default_nettype wire

// File: design/delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
  parameter type payload_t = logic,
  parameter int unsigned N = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [N-1:0] valid_q;
  payload_t data_q [N];

  if (N < 1) begin : g_bad_depth
    $error("delay_line needs at least one stage");
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int unsigned i = 1; i < N; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // payload shifts regardless of valid.
  always_ff @(posedge clk) begin
    data_q[0] <= in_data;
    for (int unsigned i = 1; i < N; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[N-1];
  assign out_data  = data_q[N-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_out_valid_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(out_valid)
  ) else $error("delay_line out_valid is unknown");

endmodule

`default_nettype wire

// File: design/line_store.sv
`timescale 1ns/1ns
`default_nettype none

module line_store
  import brisc_mem_pkg::*;
(
  input  logic      clk,
  mem_req_if.sink   req,
  output logic      read_valid,
  output mem_fill_t read_line
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [WORD_WIDTH-1:0] mem [MEM_DEPTH];  // no preload, undefined until written.

  logic [LINE_INDEX_WIDTH-1:0] line_index;
  logic [CACHE_LINE_WIDTH-1:0] line_data;
  logic                        do_store;

  // word slot of word w within the addressed line.
  function automatic int unsigned word_index(
    input logic [LINE_INDEX_WIDTH-1:0] line,
    input int unsigned w
  );
    int unsigned base;
    base = int'(line) * WORDS_IN_LINE;
    return base + w;
  endfunction

  // offset bits inside the line are dropped.
  assign line_index = req.addr[LINE_OFFSET_WIDTH +: LINE_INDEX_WIDTH];
  assign do_store   = req.valid & req.store;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // evict: whole line in one edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (do_store) begin
      for (int unsigned w = 0; w < WORDS_IN_LINE; w++) begin
        mem[word_index(line_index, w)] <= req.data[w*WORD_WIDTH +: WORD_WIDTH];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fill read
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // word 0 sits in the low bits of the line.
  always_comb begin
    for (int unsigned w = 0; w < WORDS_IN_LINE; w++) begin
      line_data[w*WORD_WIDTH +: WORD_WIDTH] = mem[word_index(line_index, w)];
    end
  end

  assign read_valid     = req.valid & ~req.store;
  assign read_line.addr = req.addr;  // echoed as issued, offset included.
  assign read_line.data = line_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the cache must stay inside the 64 lines that exist.
  a_addr_in_range: assert property (
    @(posedge clk)
    req.valid |->
      req.addr[ADDRESS_WIDTH-1:LINE_OFFSET_WIDTH+LINE_INDEX_WIDTH] == '0
  ) else $error("line_store address 0x%h beyond memory", req.addr);

  a_store_data_known: assert property (
    @(posedge clk)
    do_store |-> !$isunknown(req.data)
  ) else $error("line_store evict data unknown at 0x%h", req.addr);

endmodule

`default_nettype wire

// File: design/brisc_mem.sv
`timescale 1ns/1ns
`default_nettype none

module brisc_mem
  import brisc_mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,

  // request side.
  input  logic                        req,
  input  logic                        req_store,
  input  logic [ADDRESS_WIDTH-1:0]    req_addr,
  input  logic [CACHE_LINE_WIDTH-1:0] req_evict_data,

  // fill side, one-cycle pulse.
  output logic                        fill,
  output logic [ADDRESS_WIDTH-1:0]    fill_addr,
  output logic [CACHE_LINE_WIDTH-1:0] fill_data
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mem_req_t  req_in;
  mem_req_t  req_late;
  logic      req_late_valid;

  mem_fill_t read_line;
  logic      read_valid;
  mem_fill_t fill_line;

  assign req_in.store = req_store;
  assign req_in.addr  = req_addr;
  assign req_in.data  = req_evict_data;

  delay_line #(
    .payload_t (mem_req_t),
    .N         (MEM_REQ_DELAY)
  ) req_pipe (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (req),
    .in_data   (req_in),
    .out_valid (req_late_valid),
    .out_data  (req_late)
  );

  mem_req_if req_bus ();

  // pipeline output drives the source side.
  assign req_bus.valid = req_late_valid;
  assign req_bus.store = req_late.store;
  assign req_bus.addr  = req_late.addr;
  assign req_bus.data  = req_late.data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  line_store u_line_store (
    .clk        (clk),
    .req        (req_bus.sink),
    .read_valid (read_valid),
    .read_line  (read_line)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // reads only, stores never reach it.
  delay_line #(
    .payload_t (mem_fill_t),
    .N         (MEM_RESP_DELAY)
  ) resp_pipe (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (read_valid),
    .in_data   (read_line),
    .out_valid (fill),
    .out_data  (fill_line)
  );

  assign fill_addr = fill_line.addr;
  assign fill_data = fill_line.data;

endmodule

`default_nettype wire

// File: test/brisc_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module brisc_mem_tb
  import brisc_mem_pkg::*;
();

  localparam int LAT = MEM_REQ_DELAY + MEM_RESP_DELAY;  // issue to fill, in cycles.
  localparam int NUM_TESTS = 6;

  typedef struct {
    int                          test;
    logic                        req;
    logic                        store;
    logic [ADDRESS_WIDTH-1:0]    addr;
    logic [CACHE_LINE_WIDTH-1:0] data;
  } step_t;

  typedef struct {
    int                          due;
    int                          test;
    logic [ADDRESS_WIDTH-1:0]    addr;
    logic [CACHE_LINE_WIDTH-1:0] data;
  } fill_exp_t;

  logic                        clk;
  logic                        reset;
  logic                        req;
  logic                        req_store;
  logic [ADDRESS_WIDTH-1:0]    req_addr;
  logic [CACHE_LINE_WIDTH-1:0] req_evict_data;
  logic                        fill;
  logic [ADDRESS_WIDTH-1:0]    fill_addr;
  logic [CACHE_LINE_WIDTH-1:0] fill_data;

  step_t                       steps[$];
  fill_exp_t                   exp_q[$];
  logic [CACHE_LINE_WIDTH-1:0] ref_line [MEM_DEPTH / WORDS_IN_LINE];
  int                          test_end [1:NUM_TESTS];
  int                          test_errs [1:NUM_TESTS];
  bit                          reported [1:NUM_TESTS];
  int                          n_reported;
  int                          n_pass;
  int                          n_fail;
  int                          total_errors;
  int                          cycles;
  int                          limit;
  int                          idx;
  integer                      seed = 32'hf98b1f2c;

  brisc_mem dut (
    .clk            (clk),
    .reset          (reset),
    .req            (req),
    .req_store      (req_store),
    .req_addr       (req_addr),
    .req_evict_data (req_evict_data),
    .fill           (fill),
    .fill_addr      (fill_addr),
    .fill_data      (fill_data)
  );

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic push_step(input int t, input logic r, input logic s,
                           input logic [ADDRESS_WIDTH-1:0] a,
                           input logic [CACHE_LINE_WIDTH-1:0] d);
    step_t st;
    int    last;
    st = '{test: t, req: r, store: s, addr: a, data: d};
    last = steps.size() + ((r && !s) ? LAT : 0);  // a read finishes at its fill.
    if (last > test_end[t]) test_end[t] = last;
    steps.push_back(st);
  endtask

  task automatic idle_cycles(input int t, input int n);
    for (int i = 0; i < n; i++) push_step(t, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic issue_store(input int t, input logic [ADDRESS_WIDTH-1:0] a,
                             input logic [CACHE_LINE_WIDTH-1:0] d);
    push_step(t, 1'b1, 1'b1, a, d);
  endtask

  task automatic issue_read(input int t, input logic [ADDRESS_WIDTH-1:0] a);
    push_step(t, 1'b1, 1'b0, a, '0);
  endtask

  task automatic random_line(output logic [CACHE_LINE_WIDTH-1:0] v);
    v = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  task automatic build_table();
    logic [CACHE_LINE_WIDTH-1:0] r1, r2, r3, r4;
    idle_cycles(1, 10);  // quiet memory.
    issue_store(2, 16'h0010, 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff);
    issue_store(2, 16'h0040, 128'hdead_beef_0bad_f00d_cafe_babe_1234_5678);
    idle_cycles(2, 2);
    issue_read(2, 16'h0010);
    idle_cycles(2, 1);
    issue_read(2, 16'h0040);
    issue_store(3, 16'h0100, 128'h1111_1111_2222_2222_3333_3333_4444_4444);
    issue_store(3, 16'h0110, 128'h5555_5555_6666_6666_7777_7777_8888_8888);
    issue_store(3, 16'h0120, 128'h9999_9999_aaaa_aaaa_bbbb_bbbb_cccc_cccc);
    issue_read(3, 16'h0100);  // reads back to back, several in flight.
    issue_read(3, 16'h0110);
    issue_read(3, 16'h0120);
    issue_read(3, 16'h0010);
    issue_store(4, 16'h0200, 128'ha5a5_a5a5_5a5a_5a5a_f0f0_f0f0_0f0f_0f0f);
    issue_read(4, 16'h0200);
    issue_store(4, 16'h0200, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
    issue_read(4, 16'h0200);
    issue_store(5, 16'h0300, 128'hc001_d00d_feed_face_abad_1dea_b00b_1e55);
    issue_read(5, 16'h0304);
    issue_read(5, 16'h030c);
    issue_read(5, 16'h030f);
    random_line(r1);
    random_line(r2);
    random_line(r3);
    random_line(r4);
    issue_store(6, 16'h03e0, r1);
    issue_store(6, 16'h03f0, r2);
    issue_read(6, 16'h03f0);
    issue_store(6, 16'h03f0, r3);
    issue_store(6, 16'h03f0, r4);
    issue_read(6, 16'h03f0);
    issue_read(6, 16'h03e0);  // neighbour untouched.
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drive and check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_step(input int i);
    fill_exp_t e;
    int        line;
    if (i < steps.size()) begin
      req            = steps[i].req;
      req_store      = steps[i].store;
      req_addr       = steps[i].addr;
      req_evict_data = steps[i].data;
      line = int'(steps[i].addr[LINE_OFFSET_WIDTH +: LINE_INDEX_WIDTH]);
      if (steps[i].req && steps[i].store) begin
        ref_line[line] = steps[i].data;  // in-order pipeline, so issue time is enough.
      end else if (steps[i].req) begin
        e = '{due: i + LAT, test: steps[i].test, addr: steps[i].addr, data: ref_line[line]};
        exp_q.push_back(e);
      end
    end else begin
      req            = 1'b0;
      req_store      = 1'b0;
      req_addr       = '0;
      req_evict_data = '0;
    end
  endtask

  // unexpected pulses blame the step issued one latency earlier.
  function automatic int owner_test(input int i);
    int k;
    k = i - LAT;
    if (k < 0) k = 0;
    if (k >= steps.size()) k = steps.size() - 1;
    return steps[k].test;
  endfunction

  task automatic note_error(input int t);
    test_errs[t]++;
    total_errors++;
  endtask

  task automatic check_cycle(input int i);
    fill_exp_t e;
    bit        due_now;
    int        owner;
    due_now = (exp_q.size() != 0) && (exp_q[0].due == i);
    owner = due_now ? exp_q[0].test : owner_test(i);
    if (due_now) e = exp_q.pop_front();
    if (fill !== 1'b0 && fill !== 1'b1) begin
      $display("error: fill = %h, unknown at cycle %0d (test %0d)", fill, i, owner);
      note_error(owner);
    end else if (fill === 1'b1 && !due_now) begin
      $display("test %0d: fill pulse with no read due at cycle %0d", owner, i);
      note_error(owner);
    end else if (fill === 1'b0 && due_now) begin
      $display("test %0d: expected fill missing at cycle %0d", owner, i);
      note_error(owner);
    end else if (due_now) begin
      if (fill_addr !== e.addr) begin
        $display("error: fill_addr = %h, expected %h (test %0d)", fill_addr, e.addr, owner);
        note_error(owner);
      end
      if (fill_data !== e.data) begin
        $display("error: fill_data = %h, expected %h (test %0d)", fill_data, e.data, owner);
        note_error(owner);
      end
    end
    for (int t = 1; t <= NUM_TESTS; t++) begin
      if (!reported[t] && test_end[t] <= i) begin
        reported[t] = 1'b1;
        n_reported++;
        if (test_errs[t] == 0) n_pass++;
        else n_fail++;
        $display("test %0d %s with %0d errors", t, test_errs[t] == 0 ? "passed" : "FAILED",
                 test_errs[t]);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // run
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (!reset) begin
      cycles = cycles + 1;
      if (cycles >= limit) begin
        $display("run stuck, tests still open after %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    req            = 1'b0;
    req_store      = 1'b0;
    req_addr       = '0;
    req_evict_data = '0;
    cycles         = 0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      test_end[t]  = -1;
      test_errs[t] = 0;
      reported[t]  = 1'b0;
    end
    build_table();
    limit = steps.size() + LAT + 20;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idx = 0;
    while (n_reported < NUM_TESTS) begin
      @(negedge clk);
      check_cycle(idx);
      drive_step(idx);
      idx++;
    end
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", n_pass, n_fail, total_errors);
    if (n_fail == 0 && total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: brisc_mem.f
design/brisc_mem_pkg.sv
design/mem_req_if.sv
design/delay_line.sv
design/line_store.sv
design/brisc_mem.sv
test/brisc_mem_tb.sv
